/* spif_top.f */
spif_pkg.sv
spram.sv
uart_rx_filter.sv
io_regs.sv
boot_loader.sv
spif_top.sv
spif_chk.sv
tb_spif.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       = tb_spif
FILELIST  = spif_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb_spif.sv */
// random boot image served by a flash model, then ram readback and uart rx/tx checks
// fixed seed, single run, bounded by a watchdog sized from the image length
`timescale 1ns/1ps
`default_nettype none

module tb_spif;
  import spif_pkg::*;

  logic               clk;
  logic               arstn;
  logic               i_io_rd, i_io_wr, i_mem_rd, i_mem_wr;
  logic [ADDR_W-1:0]  i_mem_addr, i_code_addr;
  logic [WIDTH-1:0]   i_din, o_mem_dout, o_io_dout;
  logic [INSN_W-1:0]  o_insn;
  logic               o_p_hold, o_p_reset;
  logic               i_u_ready, o_u_wr, i_u_full, o_u_rd;
  logic [7:0]         o_u_dout, i_u_din, o_f_dout, i_f_din;
  logic [15:0]        o_u_rate;
  logic               i_f_ready, o_f_wr;
  logic [2:0]         o_f_format;
  logic [3:0]         o_f_rate;

  integer             seed;
  logic [7:0]         img[$];          // flash bytes after the header
  logic [7:0]         u_q[$];          // uart bytes sent to the dut
  logic [7:0]         exp_q[$];        // bytes the cpu should see
  logic [INSN_W-1:0]  code_m[2**CODE_AW];
  logic [WIDTH-1:0]   data_m[2**DATA_AW];
  logic [3:0]         exp_rate;
  logic               exp_rst;
  logic [7:0]         tx_last;
  int                 f_xfers, u_idx, tx_count, limit;
  int                 checks, errors, tests, failed, test_err0;

  spif_top dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;             // 4 ns period
  end

  task automatic tick();
    @(posedge clk);
    #1;                                // drive point
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    if (errors == test_err0) begin
      $display("test %-9s ok", name);
    end else begin
      failed++;
      $display("test %-9s failed, %0d errors", name, errors - test_err0);
    end
    test_err0 = errors;
  endtask

  function automatic int rand_range(input int lo, input int hi);
    logic [31:0] r;
    r = $random(seed);
    return lo + int'(r % (hi - lo + 1));
  endfunction

  task automatic io_read(input logic [2:0] addr, output logic [WIDTH-1:0] val);
    i_mem_addr = ADDR_W'(addr);
    i_io_rd    = 1'b1;
    #1;
    val = o_io_dout;                   // mid cycle, comb path settled
    tick();
    i_io_rd = 1'b0;
  endtask

  // ====================================================================
  // boot image and reference model
  // ====================================================================
  task automatic build_image();
    logic [31:0] r;
    logic [15:0] cnt;
    int          run, nw, sz, k;
    img.delete();
    r = $random(seed);
    img.push_back({4'b1000, r[3:0]});                // rate command
    for (run = 0; run < 2; run++) begin
      r   = $random(seed);
      nw  = rand_range(16, 40);
      sz  = rand_range(0, 3);
      cnt = 16'(nw - 1);
      img.push_back(8'hC0);                          // dest follows
      img.push_back(r[15:8]);
      img.push_back(r[7:0]);
      img.push_back(8'hC2);                          // count follows
      img.push_back(cnt[15:8]);
      img.push_back(cnt[7:0]);
      img.push_back({1'b0, r[18:16], r[19], run[0], 2'(sz)});  // run 1 to data ram
      for (k = 0; k < nw * (sz + 1); k++) begin
        r = $random(seed);
        img.push_back(r[7:0]);
      end
    end
    img.push_back(8'hE0);                            // end, cpu reset 0
  endtask

  task automatic decode_image();
    int               i, n;
    logic [7:0]       b;
    logic [15:0]      dest, cnt;
    logic [WIDTH-1:0] w;
    dest = 16'd0;
    cnt  = 16'd0;
    foreach (code_m[a]) code_m[a] = '0;              // clear leaves zeros
    foreach (data_m[a]) data_m[a] = '0;
    i = 0;
    while (i < img.size()) begin
      b = img[i];
      i++;
      if (b[7:6] == 2'b11) begin
        if (b[5]) begin
          exp_rst = b[4];
          break;
        end
        if (b[1])
          cnt = {img[i], img[i + 1]};
        else
          dest = {img[i], img[i + 1]};
        i += 2;
      end else if (b[7:6] == 2'b10) begin
        exp_rate = b[3:0];
      end else begin
        for (n = 0; n <= int'(cnt); n++) begin
          w = '0;
          repeat (int'(b[1:0]) + 1) begin
            w = {w[WIDTH-9:0], img[i]};              // high byte first
            i++;
          end
          if (b[2])
            data_m[dest[DATA_AW-1:0]] = w;
          else
            code_m[dest[CODE_AW-1:0]] = w[INSN_W-1:0];
          dest++;
        end
      end
    end
  endtask

  task automatic rx_model();
    logic esc;
    esc = 1'b0;
    exp_q.delete();
    foreach (u_q[k]) begin
      if (esc) begin
        exp_q.push_back({6'b000100, u_q[k][1:0]});   // escaped byte
        esc = 1'b0;
      end else if (u_q[k] >= 8'h10 && u_q[k] <= 8'h13) begin
        esc = (u_q[k] == 8'h10);
      end else begin
        exp_q.push_back(u_q[k]);
      end
    end
  endtask

  // ====================================================================
  // flash and uart models, watchdog
  // ====================================================================
  initial begin : flash_model
    int d;
    i_f_ready = 1'b1;
    i_f_din   = 8'h00;
    f_xfers   = 0;
    forever begin
      tick();
      if (o_f_wr) begin
        if (f_xfers < 6)
          check_val("o_f_dout", o_f_dout,
                    f_xfers == 0 ? FAST_READ : (f_xfers == 1 ? BASE_BLOCK : 8'h00));
        check_val("o_f_format", o_f_format, F_FORMAT_READ);
        i_f_ready = 1'b0;
        d = rand_range(1, 6);
        repeat (d) tick();
        i_f_din   = (f_xfers >= 5 && f_xfers - 5 < img.size()) ? img[f_xfers - 5] : 8'hFF;
        i_f_ready = 1'b1;
        f_xfers++;
      end
    end
  end

  initial begin : uart_model
    i_u_full = 1'b0;
    i_u_din  = 8'h00;
    u_idx    = 0;
    tx_count = 0;
    forever begin
      tick();
      if (o_u_wr) begin
        tx_count++;
        tx_last = o_u_dout;
      end
      if (o_u_rd) begin
        if (u_idx >= u_q.size()) begin
          errors++;
          $display("uart model: read strobe with no byte waiting at %0t", $time);
        end else begin
          u_idx++;
        end
      end
      i_u_full = (u_idx < u_q.size());
      i_u_din  = i_u_full ? u_q[u_idx] : 8'h00;
    end
  end

  initial begin : watchdog
    wait (limit > 0);
    repeat (limit) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // ====================================================================
  // test sequence
  // ====================================================================
  initial begin : main
    logic [WIDTH-1:0] v;
    logic [31:0]      r;
    logic [7:0]       b;
    logic             busy;
    int               k, got, tx0;
    seed        = 32'h4b70_1df3;
    arstn       = 1'b1;
    i_io_rd     = 1'b0;
    i_io_wr     = 1'b0;
    i_mem_rd    = 1'b0;
    i_mem_wr    = 1'b0;
    i_mem_addr  = '0;
    i_code_addr = '0;
    i_din       = '0;
    i_u_ready   = 1'b1;
    build_image();
    decode_image();
    limit = img.size() * 8 + 2 ** CODE_AW + 2000;
    #1 arstn = 1'b0;
    repeat (5) tick();
    check_val("o_f_wr", o_f_wr, 0);
    check_val("o_u_wr", o_u_wr, 0);
    check_val("o_u_rd", o_u_rd, 0);
    check_val("o_p_reset", o_p_reset, 1);
    check_val("o_p_hold", o_p_hold, 1);
    finish_test("reset");
    arstn      = 1'b1;
    i_mem_addr = ADDR_W'(IO_BOOTING);                // poll the booting flag
    busy       = 1'b1;
    while (busy) begin
      tick();
      busy = o_io_dout[0];
      if (busy)
        check_val("o_p_reset", o_p_reset, 1);
    end
    check_val("o_f_format", o_f_format, 0);
    check_val("o_f_rate", o_f_rate, exp_rate);
    check_val("o_p_reset", o_p_reset, exp_rst);
    check_val("o_p_hold", o_p_hold, 0);
    check_val("f_xfers", f_xfers, 5 + img.size());
    finish_test("boot");
    for (k = 0; k < 2 ** CODE_AW; k++) begin
      i_code_addr = ADDR_W'(k);
      tick();
      check_val($sformatf("o_insn[%0h]", k), o_insn, code_m[k]);
    end
    finish_test("code_ram");
    i_mem_rd = 1'b1;
    for (k = 0; k < 2 ** DATA_AW; k++) begin
      i_mem_addr = ADDR_W'(k);
      tick();
      check_val($sformatf("o_mem_dout[%0h]", k), o_mem_dout, data_m[k]);
    end
    i_mem_rd = 1'b0;
    finish_test("data_ram");
    for (k = 0; k < 48; k++) begin
      r = $random(seed);
      case (r[1:0])
        2'd0: u_q.push_back({6'b000100, r[9:8]});    // lone control byte
        2'd1: begin
          u_q.push_back(ESC_BYTE);                   // escape pair
          u_q.push_back(r[23:16]);
        end
        default: u_q.push_back(r[15:8]);
      endcase
    end
    rx_model();
    got = 0;
    while (got < exp_q.size()) begin
      io_read(IO_RXFULL, v);
      if (v[0]) begin
        io_read(IO_RX, v);
        check_val("rx_byte", v[7:0], exp_q[got]);
        got++;
      end
    end
    repeat (8) tick();
    io_read(IO_RXFULL, v);
    check_val("rx_full", v, 0);
    check_val("u_idx", u_idx, u_q.size());
    finish_test("uart_rx");
    v          = WIDTH'(rand_range(0, 65535));
    i_mem_addr = ADDR_W'(IO_TX_RATE);
    i_din      = v;
    i_io_wr    = 1'b1;
    tick();
    i_io_wr = 1'b0;
    check_val("o_u_rate", o_u_rate, v[15:0]);
    b          = 8'(rand_range(0, 255));
    k          = rand_range(2, 9);
    tx0        = tx_count;
    i_u_ready  = 1'b0;                               // uart busy
    i_mem_addr = ADDR_W'(IO_RX);
    i_din      = WIDTH'(b);
    i_io_wr    = 1'b1;
    repeat (k) begin
      #1;
      check_val("o_p_hold", o_p_hold, 1);
      tick();
    end
    i_u_ready = 1'b1;
    #1;
    check_val("o_p_hold", o_p_hold, 0);
    tick();
    i_io_wr = 1'b0;
    repeat (4) tick();
    check_val("o_u_wr count", tx_count - tx0, 1);
    check_val("o_u_dout", tx_last, b);
    finish_test("uart_tx");
    errors += dut_i.chk_i.fails;
    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, checks, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* spif_chk.sv */
// strobe and loader write checks, bound into every spif_top
// loader write overlap is only checked while the flash stream is open
`timescale 1ns/1ps
`default_nettype none

module spif_chk (
  input logic       clk,
  input logic       arstn,
  input logic       i_f_ready,
  input logic       o_f_wr,
  input logic       o_u_wr,
  input logic       code_wr,
  input logic       data_wr,
  input logic [2:0] o_f_format
);

  int fails = 0;

  // a transfer only starts on a ready flash
  a_f_wr_ready: assert property (@(posedge clk) disable iff (!arstn)
    o_f_wr |-> $past(i_f_ready))
    else begin
      $error("o_f_wr raised while i_f_ready was low");
      fails++;
    end

  a_f_wr_pulse: assert property (@(posedge clk) disable iff (!arstn)
    o_f_wr |=> !o_f_wr)
    else begin
      $error("o_f_wr high two cycles in a row");
      fails++;
    end

  a_u_wr_pulse: assert property (@(posedge clk) disable iff (!arstn)
    o_u_wr |=> !o_u_wr)
    else begin
      $error("o_u_wr high two cycles in a row");
      fails++;
    end

  // ram clear writes both, stream writes one
  a_one_ram: assert property (@(posedge clk) disable iff (!arstn)
    (o_f_format != 3'd0) |-> !(code_wr && data_wr))
    else begin
      $error("loader wrote code and data ram in one cycle");
      fails++;
    end

endmodule

bind spif_top spif_chk chk_i (
  .clk(clk),
  .arstn(arstn),
  .i_f_ready(i_f_ready),
  .o_f_wr(o_f_wr),
  .o_u_wr(o_u_wr),
  .code_wr(code_wr),
  .data_wr(data_wr),
  .o_f_format(o_f_format)
);

`default_nettype wire

/* spif_top.sv */
// boot controller top, loader writes take the ram ports and hold the cpu
// only the low CODE_AW/DATA_AW address bits reach the rams
`timescale 1ns/1ps
`default_nettype none

module spif_top (
  input  logic                        clk,
  input  logic                        arstn,
  input  logic                        i_io_rd,      // cpu side
  input  logic                        i_io_wr,
  input  logic                        i_mem_rd,
  input  logic                        i_mem_wr,
  input  logic [spif_pkg::ADDR_W-1:0] i_mem_addr,
  input  logic [spif_pkg::WIDTH-1:0]  i_din,
  output logic [spif_pkg::WIDTH-1:0]  o_mem_dout,
  output logic [spif_pkg::WIDTH-1:0]  o_io_dout,
  input  logic [spif_pkg::ADDR_W-1:0] i_code_addr,
  output logic [spif_pkg::INSN_W-1:0] o_insn,
  output logic                        o_p_hold,
  output logic                        o_p_reset,
  input  logic                        i_u_ready,    // uart side
  output logic                        o_u_wr,
  output logic [7:0]                  o_u_dout,
  input  logic                        i_u_full,
  output logic                        o_u_rd,
  input  logic [7:0]                  i_u_din,
  output logic [15:0]                 o_u_rate,
  input  logic                        i_f_ready,    // flash side
  output logic                        o_f_wr,
  output logic [7:0]                  o_f_dout,
  output logic [2:0]                  o_f_format,
  output logic [3:0]                  o_f_rate,
  input  logic [7:0]                  i_f_din
);
  import spif_pkg::*;

  logic [7:0]         rx_byte;
  logic               rx_full;
  logic               rx_clear;
  logic               iobusy;
  logic               booting;
  logic               code_wr;     // loader strobes
  logic               data_wr;
  logic [15:0]        dest;
  logic [WIDTH-1:0]   word;
  logic [CODE_AW-1:0] code_ia;
  logic [DATA_AW-1:0] data_ia;
  logic [WIDTH-1:0]   data_din;

  assign o_p_hold = code_wr | data_wr | iobusy;
  assign code_ia  = code_wr ? dest[CODE_AW-1:0] : i_code_addr[CODE_AW-1:0];
  assign data_ia  = data_wr ? dest[DATA_AW-1:0] : i_mem_addr[DATA_AW-1:0];
  assign data_din = data_wr ? word : i_din;

  uart_rx_filter rx_filter_i (
    .clk(clk), .arstn(arstn),
    .i_u_full(i_u_full), .i_u_din(i_u_din), .i_clear(rx_clear),
    .o_u_rd(o_u_rd), .o_rx_byte(rx_byte), .o_rx_full(rx_full)
  );

  io_regs io_regs_i (
    .clk(clk), .arstn(arstn),
    .i_io_rd(i_io_rd), .i_io_wr(i_io_wr), .i_addr(i_mem_addr[2:0]), .i_din(i_din),
    .i_rx_byte(rx_byte), .i_rx_full(rx_full), .i_u_ready(i_u_ready),
    .i_f_din(i_f_din), .i_booting(booting), .o_io_dout(o_io_dout),
    .o_rx_clear(rx_clear), .o_u_wr(o_u_wr), .o_u_dout(o_u_dout),
    .o_u_rate(o_u_rate), .o_iobusy(iobusy)
  );

  boot_loader boot_loader_i (
    .clk(clk), .arstn(arstn),
    .i_f_ready(i_f_ready), .i_f_din(i_f_din), .o_f_wr(o_f_wr), .o_f_dout(o_f_dout),
    .o_f_format(o_f_format), .o_f_rate(o_f_rate), .o_p_reset(o_p_reset),
    .o_booting(booting), .o_code_wr(code_wr), .o_data_wr(data_wr),
    .o_dest(dest), .o_word(word)
  );

  // code ram, read every cycle the cpu runs
  spram #(.ADDR_W(CODE_AW), .DATA_W(INSN_W)) code_ram (
    .clk(clk), .i_addr(code_ia), .i_din(word[INSN_W-1:0]),
    .i_we(code_wr), .i_re(~o_p_hold), .o_dout(o_insn)
  );

  // data ram, cpu reads frozen while held
  spram #(.ADDR_W(DATA_AW), .DATA_W(WIDTH)) data_ram (
    .clk(clk), .i_addr(data_ia), .i_din(data_din),
    .i_we(data_wr | i_mem_wr), .i_re(i_mem_rd & ~o_p_hold), .o_dout(o_mem_dout)
  );

endmodule

`default_nettype wire

/* boot_loader.sv */
// clears both rams, sends a fast read header, then runs the flash byte stream
// stream writes only while the flash is ready, stops for good on an end byte
`timescale 1ns/1ps
`default_nettype none

module boot_loader (
  input  logic                       clk,
  input  logic                       arstn,
  input  logic                       i_f_ready,
  input  logic [7:0]                 i_f_din,
  output logic                       o_f_wr,
  output logic [7:0]                 o_f_dout,
  output logic [2:0]                 o_f_format,
  output logic [3:0]                 o_f_rate,
  output logic                       o_p_reset,
  output logic                       o_booting,
  output logic                       o_code_wr,
  output logic                       o_data_wr,
  output logic [15:0]                o_dest,
  output logic [spif_pkg::WIDTH-1:0] o_word
);
  import spif_pkg::*;

  logic               clearing;   // ram clear in progress
  logic [CODE_AW-1:0] clr_cnt;
  logic [2:0]         b_state;    // header step, stream or done
  logic [1:0]         b_mode;     // meaning of next stream byte
  logic               b_high;     // next dest/count byte is the high one
  logic               space;      // run goes to data ram
  logic [1:0]         bytes;      // bytes per word minus one
  logic [1:0]         bytecount;
  logic [15:0]        b_count;    // words left minus one
  logic               f_ok;
  boot_byte_u         fb;

  assign f_ok      = i_f_ready & ~o_f_wr;
  assign fb        = boot_byte_u'(i_f_din);
  assign o_booting = (b_state != ST_DONE);

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      clearing   <= 1'b1;
      clr_cnt    <= '0;
      o_code_wr  <= 1'b1;          // clear writes from the first cycle
      o_data_wr  <= 1'b1;
      o_dest     <= 16'd0;
      o_word     <= '0;            // zero is what the clear writes
      o_f_wr     <= 1'b0;
      o_f_dout   <= 8'h00;
      o_f_format <= 3'd0;
      o_f_rate   <= F_RATE_POR;
      o_p_reset  <= 1'b1;
      b_state    <= ST_HDR0;
      b_mode     <= MODE_CMD;
      b_high     <= 1'b0;
      space      <= 1'b0;
      bytes      <= 2'd0;
      bytecount  <= 2'd0;
      b_count    <= 16'd0;
    end else begin
      o_code_wr <= 1'b0;
      o_data_wr <= 1'b0;
      o_f_wr    <= 1'b0;
      if (o_code_wr | o_data_wr)
        o_dest <= o_dest + 16'd1;  // bump after each word
      // ================================================================
      // ram clear, 2^CODE_AW + 1 cycles of writes
      // ================================================================
      if (clearing) begin
        o_code_wr <= 1'b1;
        o_data_wr <= 1'b1;
        clr_cnt   <= clr_cnt + 1'b1;
        if (&clr_cnt)
          clearing <= 1'b0;
      end else if (f_ok && (b_state != ST_DONE)) begin
        o_f_wr <= 1'b1;            // next byte, every step
        if (b_state != ST_STREAM) begin
          b_state <= b_state + 3'd1;
          if (b_state == ST_HDR0) begin
            o_f_dout   <= FAST_READ;
            o_f_format <= F_FORMAT_READ;  // cs# low from here
          end else if (b_state == ST_HDR0 + 3'd1) begin
            o_f_dout <= BASE_BLOCK;
          end else begin
            o_f_dout <= 8'h00;     // address low and dummy
          end
        end else begin
          // ============================================================
          // stream interpreter
          // ============================================================
          case (b_mode)
            MODE_CMD: begin
              if (fb.cmd.cls == CLS_MODE) begin
                if (fb.cmd.last) begin
                  o_f_wr     <= 1'b0;          // no further transfer
                  o_f_format <= 3'd0;          // release cs#
                  o_p_reset  <= fb.cmd.rst;
                  b_state    <= ST_DONE;
                end else begin
                  b_mode <= fb.cmd.size[1] ? MODE_COUNT : MODE_DEST;
                  b_high <= 1'b1;
                end
              end else if (fb.cmd.cls == CLS_RATE) begin
                o_f_rate <= fb.raw[3:0];
              end else begin
                b_mode    <= MODE_DATA;
                space     <= fb.cmd.spare[0];  // bit 2
                bytes     <= fb.cmd.size;
                bytecount <= fb.cmd.size;
              end
            end
            MODE_DATA: begin
              if (bytecount == bytes)
                o_word <= WIDTH'(fb.raw);      // first byte of the word
              else
                o_word <= {o_word[WIDTH-9:0], fb.raw};
              if (bytecount != 2'd0) begin
                bytecount <= bytecount - 2'd1;
              end else begin
                bytecount <= bytes;
                o_code_wr <= ~space;
                o_data_wr <= space;
                if (b_count != 16'd0)
                  b_count <= b_count - 16'd1;
                else
                  b_mode <= MODE_CMD;          // run finished
              end
            end
            MODE_DEST: begin
              if (b_high) begin
                o_dest[15:8] <= fb.raw;
                b_high       <= 1'b0;
              end else begin
                o_dest[7:0] <= fb.raw;
                b_mode      <= MODE_CMD;
              end
            end
            default: begin
              if (b_high) begin
                b_count[15:8] <= fb.raw;
                b_high        <= 1'b0;
              end else begin
                b_count[7:0] <= fb.raw;
                b_mode       <= MODE_CMD;
              end
            end
          endcase
        end
      end
    end
  end

endmodule

`default_nettype wire

/* io_regs.sv */
// cpu i/o registers at i_addr, unused offsets read zero
// a tx write holds the cpu through o_iobusy until the uart takes it
`timescale 1ns/1ps
`default_nettype none

module io_regs (
  input  logic                       clk,
  input  logic                       arstn,
  input  logic                       i_io_rd,
  input  logic                       i_io_wr,
  input  logic [2:0]                 i_addr,
  input  logic [spif_pkg::WIDTH-1:0] i_din,
  input  logic [7:0]                 i_rx_byte,
  input  logic                       i_rx_full,
  input  logic                       i_u_ready,
  input  logic [7:0]                 i_f_din,
  input  logic                       i_booting,
  output logic [spif_pkg::WIDTH-1:0] o_io_dout,
  output logic                       o_rx_clear,
  output logic                       o_u_wr,
  output logic [7:0]                 o_u_dout,
  output logic [15:0]                o_u_rate,
  output logic                       o_iobusy
);
  import spif_pkg::*;

  logic tx_sel;   // cpu writes a tx byte
  logic tx_ok;    // uart can take it now
  logic tx_busy;
  logic rate_we;

  assign tx_sel     = i_io_wr & (i_addr == IO_RX);
  assign tx_ok      = i_u_ready & ~o_u_wr;       // ready not yet updated
  assign tx_busy    = ~i_u_ready;
  assign o_iobusy   = tx_sel & ~tx_ok;           // wait state
  assign rate_we    = i_io_wr & (i_addr == IO_TX_RATE) & ~o_iobusy;
  assign o_rx_clear = i_io_rd & (i_addr == IO_RX) & ~o_iobusy;

  // ====================================================================
  // read mux
  // ====================================================================
  always_comb begin
    case (i_addr)
      IO_RX:      o_io_dout = WIDTH'(i_rx_byte);
      IO_RXFULL:  o_io_dout = WIDTH'(i_rx_full);
      IO_TX_RATE: o_io_dout = WIDTH'(tx_busy);   // emit would stall
      IO_FLASH:   o_io_dout = WIDTH'(i_f_din);   // last flash byte
      IO_BOOTING: o_io_dout = WIDTH'(i_booting);
      default:    o_io_dout = '0;
    endcase
  end

  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      o_u_wr   <= 1'b0;
      o_u_rate <= UART_RATE_POR;
    end else begin
      o_u_wr <= tx_sel & tx_ok;                  // strobe after accept
      if (rate_we)
        o_u_rate <= i_din[15:0];
    end
  end

  // tx byte
  always_ff @(posedge clk) begin
    if (tx_sel & tx_ok)
      o_u_dout <= i_din[7:0];
  end

endmodule

`default_nettype wire

/* uart_rx_filter.sv */
// uart receive filter, 0x10..0x13 never reach the cpu
// 0x10 then x delivers 0x10 + x[1:0], a byte waits in the uart while full
`timescale 1ns/1ps
`default_nettype none

module uart_rx_filter (
  input  logic       clk,
  input  logic       arstn,
  input  logic       i_u_full,
  input  logic [7:0] i_u_din,
  input  logic       i_clear,
  output logic       o_u_rd,
  output logic [7:0] o_rx_byte,
  output logic       o_rx_full
);
  import spif_pkg::*;

  logic       esc;      // last byte was 0x10
  logic       rx_ok;    // uart byte not yet consumed
  logic       is_ctrl;  // 0x10..0x13
  logic       swallow;  // control byte, drop it
  logic       take;     // deliver to holding reg
  logic [7:0] rx_next;

  assign rx_ok   = i_u_full & ~o_u_rd;          // o_u_rd still in flight
  assign is_ctrl = (i_u_din[7:2] == ESC_BYTE[7:2]);
  assign swallow = rx_ok & ~esc & is_ctrl;
  assign take    = rx_ok & ~o_rx_full & (esc | ~is_ctrl);
  assign rx_next = esc ? (ESC_BYTE | {6'd0, i_u_din[1:0]}) : i_u_din;

  // ====================================================================
  // filter state
  // ====================================================================
  always_ff @(posedge clk or negedge arstn) begin
    if (!arstn) begin
      esc       <= 1'b0;
      o_u_rd    <= 1'b0;
      o_rx_full <= 1'b0;
    end else begin
      o_u_rd <= swallow | take;                 // one pulse per byte
      if (i_clear)
        o_rx_full <= 1'b0;                      // cpu read the byte
      if (take)
        o_rx_full <= 1'b1;
      if (swallow)
        esc <= (i_u_din[1:0] == 2'b00);         // only 0x10 escapes
      else if (take)
        esc <= 1'b0;
    end
  end

  // held byte
  always_ff @(posedge clk) begin
    if (take)
      o_rx_byte <= rx_next;
  end

endmodule

`default_nettype wire

/* spram.sv */
// single-port ram, write-first, read data only updates while i_re is high
// contents are undefined until written
`timescale 1ns/1ps
`default_nettype none

module spram #(
  parameter int ADDR_W = 8,
  parameter int DATA_W = 18
) (
  input  logic              clk,
  input  logic [ADDR_W-1:0] i_addr,
  input  logic [DATA_W-1:0] i_din,
  input  logic              i_we,
  input  logic              i_re,
  output logic [DATA_W-1:0] o_dout
);

  logic [DATA_W-1:0] mem [2**ADDR_W];

  always_ff @(posedge clk) begin
    if (i_we)
      mem[i_addr] <= i_din;
    if (i_re)
      o_dout <= i_we ? i_din : mem[i_addr];  // new data on a write
  end

endmodule

`default_nettype wire

/* spif_pkg.sv */
// shared widths, cpu i/o map and flash boot constants
// flash bytes are plaintext and the boot image starts at byte 5 of the read
`default_nettype none

package spif_pkg;

  // ====================================================================
  // sizes
  // ====================================================================
  localparam int WIDTH   = 18;                // data cell width
  localparam int CODE_AW = 8;                 // log2 code words
  localparam int DATA_AW = 8;                 // log2 data cells
  localparam int INSN_W  = 16;                // instruction width
  localparam int ADDR_W  = 15;                // cpu address width

  // ====================================================================
  // flash and uart
  // ====================================================================
  localparam logic [7:0]  BASE_BLOCK    = 8'd0;     // first 64KB sector
  localparam logic [7:0]  FAST_READ     = 8'h0B;    // read opcode with dummy
  localparam logic [15:0] UART_RATE_POR = 16'd868;  // baud divisor after reset
  localparam logic [3:0]  F_RATE_POR    = 4'd7;     // slow sclk until told
  localparam logic [2:0]  F_FORMAT_READ = 3'd2;     // cs# low, streaming
  localparam logic [7:0]  ESC_BYTE      = 8'h10;    // 0x10..0x13 are control

  // cpu i/o offsets, i_mem_addr[2:0]
  localparam logic [2:0] IO_RX      = 3'd0;   // rx byte / tx write
  localparam logic [2:0] IO_RXFULL  = 3'd1;
  localparam logic [2:0] IO_TX_RATE = 3'd2;   // tx busy / baud write
  localparam logic [2:0] IO_FLASH   = 3'd3;
  localparam logic [2:0] IO_BOOTING = 3'd5;

  // boot sequencer steps and stream interpreter modes
  localparam logic [2:0] ST_DONE    = 3'd0;
  localparam logic [2:0] ST_HDR0    = 3'd1;   // 1..6 send the read header
  localparam logic [2:0] ST_STREAM  = 3'd7;
  localparam logic [1:0] MODE_CMD   = 2'b00;
  localparam logic [1:0] MODE_DATA  = 2'b01;
  localparam logic [1:0] MODE_DEST  = 2'b10;
  localparam logic [1:0] MODE_COUNT = 2'b11;
  localparam logic [1:0] CLS_MODE   = 2'b11;  // end, or dest/count follows
  localparam logic [1:0] CLS_RATE   = 2'b10;

  // one flash byte, taken as data or as a command
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [1:0] cls;    // 11 end/mode, 10 rate, else data run
      logic       last;   // end of boot
      logic       rst;    // cpu reset level after boot
      logic [1:0] spare;  // bit 2 selects data ram
      logic [1:0] size;   // bytes per word minus one
    } cmd;
  } boot_byte_u;

endpackage

`default_nettype wire
